/* fma_config.svh */
/*
 * width, bias and tag size macros for the bfloat fused multiply-add unit
 */
`ifndef FMA_CONFIG_SVH
`define FMA_CONFIG_SVH

////////////////////////////////////////
// number format
`define FMA_FLEN   16   // sign + expo + frac
`define FMA_EXPO_W 8
`define FMA_FRAC_W 7
`define FMA_BIAS   127

////////////////////////////////////////
// datapath
// adder working mantissa: 3 integer bits, 21 below the point
`define FMA_WORK_W 24

// issue tag, one per in-flight op
`define FMA_ID_W   4

`endif

/* fma_pkg.sv */
/*
 * shared vector types and op/stage enums for the fused multiply-add unit
 */
`default_nettype none

`include "fma_config.svh"

package fma_pkg;

  ////////////////////////////////////////
  // data widths
  typedef logic [`FMA_FLEN-1:0] fp_t;    // operand or result
  typedef logic [`FMA_EXPO_W:0] expo_t;  // extra bit for over/underflow
  typedef logic [2*(`FMA_FRAC_W+1)-1:0] prod_t;  // exact 8x8 product
  typedef logic [`FMA_WORK_W-1:0] work_t;
  typedef logic [`FMA_ID_W-1:0] id_t;

  ////////////////////////////////////////
  // operations
  typedef enum logic [2:0] {
    op_fmul,
    op_fadd,
    op_fsub,
    op_fmadd,
    op_fmsub
  } fp_op_e;

  // stage occupancy
  typedef enum logic {mul_idle, mul_busy} mul_state_e;
  typedef enum logic {add_idle, add_busy} add_state_e;

endpackage

`default_nettype wire

/* fp_mul.sv */
/*
 * two-stage mantissa multiplier, fmul write-back
 * and raw product hand-off for fmadd/fmsub
 */
`timescale 1ns/1ps
`default_nettype none

`include "fma_config.svh"

module fp_mul (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               issue_fire,
  input  fma_pkg::fp_op_e    issue_op,
  input  fma_pkg::id_t       issue_id,
  input  fma_pkg::fp_t       rs1,
  input  fma_pkg::fp_t       rs2,
  input  fma_pkg::fp_t       rs3,
  output logic               mul_wb_valid,
  output fma_pkg::id_t       mul_wb_id,
  output fma_pkg::fp_t       mul_wb_result,
  output logic               prod_valid,
  output fma_pkg::id_t       prod_id,
  output logic               prod_sign,
  output fma_pkg::expo_t     prod_expo,
  output fma_pkg::prod_t     prod_mant,
  output fma_pkg::fp_t       addend,
  output logic               addend_neg
);

  localparam int PROD_W   = 2 * (`FMA_FRAC_W + 1);
  localparam int EXPO_MAX = (1 << `FMA_EXPO_W) - 1;  // 255, all ones = inf

  ////////////////////////////////////////
  // stage 1: sign, exponent sum, exact mantissa product
  logic                    is_mul;
  logic [`FMA_EXPO_W-1:0]  e1;
  logic [`FMA_EXPO_W-1:0]  e2;
  logic [`FMA_EXPO_W+1:0]  e_sum;  // up to 510
  logic                    in_zero;

  fma_pkg::mul_state_e     s1_state;
  logic                    s1_fused;
  logic                    s1_sub;
  fma_pkg::id_t            s1_id;
  logic                    s1_sign;
  fma_pkg::expo_t          s1_expo;
  fma_pkg::prod_t          s1_mant;
  fma_pkg::fp_t            s1_addend;

  assign is_mul = issue_fire & (issue_op == fma_pkg::op_fmul ||
                                issue_op == fma_pkg::op_fmadd ||
                                issue_op == fma_pkg::op_fmsub);

  assign e1    = rs1[`FMA_FLEN-2 -: `FMA_EXPO_W];
  assign e2    = rs2[`FMA_FLEN-2 -: `FMA_EXPO_W];
  assign e_sum = {2'b00, e1} + {2'b00, e2};

  // zero expo reads as zero, and a product below expo 0 flushes here
  assign in_zero = (e1 == '0) | (e2 == '0) | (e_sum < `FMA_BIAS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_state <= fma_pkg::mul_idle;
      s1_fused <= 1'b0;
    end else begin
      s1_state <= is_mul ? fma_pkg::mul_busy : fma_pkg::mul_idle;
      s1_fused <= (issue_op != fma_pkg::op_fmul);  // only looked at when busy
    end
  end

  always_ff @(posedge clk) begin
    if (is_mul) begin
      s1_id     <= issue_id;
      s1_sign   <= rs1[`FMA_FLEN-1] ^ rs2[`FMA_FLEN-1];
      s1_sub    <= (issue_op == fma_pkg::op_fmsub);
      s1_addend <= rs3;
      if (in_zero) begin
        s1_expo <= '0;
        s1_mant <= '0;  // zero product is all-zero mant and expo
      end else begin
        s1_expo <= fma_pkg::expo_t'(e_sum - `FMA_BIAS);
        s1_mant <= {1'b1, rs1[`FMA_FRAC_W-1:0]} * {1'b1, rs2[`FMA_FRAC_W-1:0]};
      end
    end
  end

  ////////////////////////////////////////
  // stage 2: fmul normalize + truncate, or pass the raw product on
  logic [`FMA_EXPO_W+1:0]  fin_expo;
  logic [`FMA_FRAC_W-1:0]  fin_frac;
  fma_pkg::fp_t            fmul_res;
  fma_pkg::mul_state_e     s2_state;
  logic                    s2_fused;
  fma_pkg::id_t            s2_id;

  // product in [1,4), top bit set means one step up
  assign fin_expo = {1'b0, s1_expo} + {{(`FMA_EXPO_W+1){1'b0}}, s1_mant[PROD_W-1]};
  assign fin_frac = s1_mant[PROD_W-1] ? s1_mant[PROD_W-2 -: `FMA_FRAC_W]
                                      : s1_mant[PROD_W-3 -: `FMA_FRAC_W];

  always_comb begin
    if (fin_expo == '0) begin
      fmul_res = {s1_sign, {(`FMA_FLEN-1){1'b0}}};  // zero or underflow
    end else if (fin_expo >= EXPO_MAX) begin
      fmul_res = {s1_sign, {`FMA_EXPO_W{1'b1}}, {`FMA_FRAC_W{1'b0}}};  // signed inf
    end else begin
      fmul_res = {s1_sign, fin_expo[`FMA_EXPO_W-1:0], fin_frac};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_state <= fma_pkg::mul_idle;
      s2_fused <= 1'b0;
    end else begin
      s2_state <= s1_state;
      s2_fused <= s1_fused;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_state == fma_pkg::mul_busy) begin
      s2_id         <= s1_id;
      mul_wb_result <= fmul_res;
      prod_sign     <= s1_sign;
      prod_expo     <= s1_expo;  // unrounded, not yet normalized
      prod_mant     <= s1_mant;
      addend        <= s1_addend;
      addend_neg    <= s1_sub;
    end
  end

  assign mul_wb_valid = (s2_state == fma_pkg::mul_busy) & ~s2_fused;
  assign prod_valid   = (s2_state == fma_pkg::mul_busy) & s2_fused;
  assign mul_wb_id    = s2_id;
  assign prod_id      = s2_id;

  // adder expects the leading one of a nonzero product at bit 15 or 14
  a_prod_norm: assert property (@(posedge clk) disable iff (!rst_n)
    prod_valid |-> (prod_mant == '0) || (prod_mant[PROD_W-1 -: 2] != 2'b00));

endmodule

`default_nettype wire

/* fadd_prep.sv */
/*
 * fadd/fsub operand ordering and exponent difference,
 * held in a one-entry buffer until the adder takes it
 */
`timescale 1ns/1ps
`default_nettype none

`include "fma_config.svh"

module fadd_prep (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             issue_fire,
  input  fma_pkg::fp_op_e  issue_op,
  input  fma_pkg::id_t     issue_id,
  input  fma_pkg::fp_t     rs1,
  input  fma_pkg::fp_t     rs2,
  input  logic             pend_take,
  output logic             prep_ready,
  output logic             pend_valid,
  output fma_pkg::id_t     pend_id,
  output fma_pkg::fp_t     pend_big,
  output fma_pkg::fp_t     pend_small,
  output fma_pkg::expo_t   pend_diff,
  output logic             pend_sub
);

  logic                    is_add;
  fma_pkg::fp_t            b_in;  // rs2 with fsub sign applied
  fma_pkg::expo_t          diff_ab;
  fma_pkg::expo_t          diff_ba;
  logic                    swap;

  assign is_add = issue_fire & (issue_op == fma_pkg::op_fadd ||
                                issue_op == fma_pkg::op_fsub);

  assign b_in = (issue_op == fma_pkg::op_fsub) ? {~rs2[`FMA_FLEN-1], rs2[`FMA_FLEN-2:0]}
                                               : rs2;

  ////////////////////////////////////////
  // exponent difference both ways, msb is the sign
  assign diff_ab = {1'b0, rs1[`FMA_FLEN-2 -: `FMA_EXPO_W]} -
                   {1'b0, b_in[`FMA_FLEN-2 -: `FMA_EXPO_W]};
  assign diff_ba = {1'b0, b_in[`FMA_FLEN-2 -: `FMA_EXPO_W]} -
                   {1'b0, rs1[`FMA_FLEN-2 -: `FMA_EXPO_W]};

  // rs2 larger: bigger expo, or same expo and bigger fraction
  assign swap = diff_ab[`FMA_EXPO_W] ? 1'b1 :
                (diff_ab != '0)     ? 1'b0 :
                (rs1[`FMA_FRAC_W-1:0] < b_in[`FMA_FRAC_W-1:0]);

  ////////////////////////////////////////
  // one-entry buffer
  assign prep_ready = ~pend_valid | pend_take;  // empty or leaving now

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_valid <= 1'b0;
    end else if (is_add) begin
      pend_valid <= 1'b1;
    end else if (pend_take) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (is_add) begin
      pend_id    <= issue_id;
      pend_big   <= swap ? b_in : rs1;
      pend_small <= swap ? rs1 : b_in;
      pend_diff  <= swap ? diff_ba : diff_ab;  // always the positive one
      pend_sub   <= rs1[`FMA_FLEN-1] ^ b_in[`FMA_FLEN-1];  // effective subtract
    end
  end

  // top gates issue with prep_ready, so a full buffer never gets overwritten
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    is_add |-> (!pend_valid || pend_take));

  a_take_valid: assert property (@(posedge clk) disable iff (!rst_n)
    pend_take |-> pend_valid);

endmodule

`default_nettype wire

/* fp_add.sv */
/*
 * two-stage adder: picks a fused product or a queued fadd/fsub,
 * aligns and adds, then normalizes, truncates and writes back
 */
`timescale 1ns/1ps
`default_nettype none

`include "fma_config.svh"

module fp_add (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             prod_valid,
  input  fma_pkg::id_t     prod_id,
  input  logic             prod_sign,
  input  fma_pkg::expo_t   prod_expo,
  input  fma_pkg::prod_t   prod_mant,
  input  fma_pkg::fp_t     addend,
  input  logic             addend_neg,
  input  logic             pend_valid,
  input  fma_pkg::id_t     pend_id,
  input  fma_pkg::fp_t     pend_big,
  input  fma_pkg::fp_t     pend_small,
  input  fma_pkg::expo_t   pend_diff,
  input  logic             pend_sub,
  output logic             pend_take,
  output logic             add_wb_valid,
  output fma_pkg::id_t     add_wb_id,
  output fma_pkg::fp_t     add_wb_result
);

  localparam int PROD_W   = 2 * (`FMA_FRAC_W + 1);
  localparam int PT       = `FMA_WORK_W - 3;        // hidden bit lands on bit 21
  localparam int OP_SH    = PT - `FMA_FRAC_W;       // 8-bit mantissa to working
  localparam int PR_SH    = PT - (PROD_W - 1);      // product, top bit set
  localparam int EXPO_MAX = (1 << `FMA_EXPO_W) - 1;

  ////////////////////////////////////////
  // product operand vs addend, ordered here
  fma_pkg::expo_t   p_expo;
  fma_pkg::work_t   p_work;
  logic             a_sign;
  fma_pkg::expo_t   a_expo;
  fma_pkg::work_t   a_work;
  logic             p_big;

  // normalize the product so both sides carry the hidden bit at PT
  assign p_expo = prod_expo + {{`FMA_EXPO_W{1'b0}}, prod_mant[PROD_W-1]};
  assign p_work = prod_mant[PROD_W-1] ? fma_pkg::work_t'(prod_mant) << PR_SH
                                      : fma_pkg::work_t'(prod_mant) << (PR_SH + 1);

  assign a_sign = addend[`FMA_FLEN-1] ^ addend_neg;  // fmsub flips rs3
  assign a_expo = {1'b0, addend[`FMA_FLEN-2 -: `FMA_EXPO_W]};
  assign a_work = (a_expo == '0) ? '0   // zero expo reads as zero
                : fma_pkg::work_t'({1'b1, addend[`FMA_FRAC_W-1:0]}) << OP_SH;

  assign p_big = (p_expo > a_expo) || (p_expo == a_expo && p_work >= a_work);

  ////////////////////////////////////////
  // source select, fused product first
  logic             big_sign;
  fma_pkg::expo_t   big_expo;
  fma_pkg::work_t   big_work;
  fma_pkg::work_t   small_work;
  fma_pkg::expo_t   diff;
  logic             sub;
  fma_pkg::work_t   aligned;
  fma_pkg::work_t   sum;

  assign pend_take = pend_valid & ~prod_valid;

  always_comb begin
    if (prod_valid) begin
      big_sign   = p_big ? prod_sign : a_sign;
      big_expo   = p_big ? p_expo : a_expo;
      big_work   = p_big ? p_work : a_work;
      small_work = p_big ? a_work : p_work;
      diff       = p_big ? (p_expo - a_expo) : (a_expo - p_expo);
      sub        = prod_sign ^ a_sign;
    end else begin
      big_sign   = pend_big[`FMA_FLEN-1];
      big_expo   = {1'b0, pend_big[`FMA_FLEN-2 -: `FMA_EXPO_W]};
      big_work   = (pend_big[`FMA_FLEN-2 -: `FMA_EXPO_W] == '0) ? '0
                 : fma_pkg::work_t'({1'b1, pend_big[`FMA_FRAC_W-1:0]}) << OP_SH;
      small_work = (pend_small[`FMA_FLEN-2 -: `FMA_EXPO_W] == '0) ? '0
                 : fma_pkg::work_t'({1'b1, pend_small[`FMA_FRAC_W-1:0]}) << OP_SH;
      diff       = pend_diff;
      sub        = pend_sub;
    end
  end

  // bits shifted past the working width are gone, shift >= 24 gives 0
  assign aligned = small_work >> diff;
  assign sum     = sub ? (big_work - aligned) : (big_work + aligned);  // big >= small

  ////////////////////////////////////////
  // stage 1 register
  fma_pkg::add_state_e  s1_state;
  fma_pkg::id_t         s1_id;
  logic                 s1_sign;
  fma_pkg::expo_t       s1_expo;
  fma_pkg::work_t       s1_sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_state <= fma_pkg::add_idle;
    end else begin
      s1_state <= (prod_valid | pend_valid) ? fma_pkg::add_busy : fma_pkg::add_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid | pend_valid) begin
      s1_id   <= prod_valid ? prod_id : pend_id;
      s1_sign <= big_sign;
      s1_expo <= big_expo;
      s1_sum  <= sum;
    end
  end

  ////////////////////////////////////////
  // stage 2: normalize, truncate, flush or saturate
  logic [4:0]            msb;  // leading one position
  fma_pkg::work_t        norm;
  logic signed [10:0]    exp_n;
  fma_pkg::fp_t          res;

  always_comb begin
    msb = '0;
    for (int i = 0; i < `FMA_WORK_W; i++) begin
      if (s1_sum[i]) begin
        msb = i[4:0];
      end
    end
  end

  // leading one to bit PT+1, fraction sits right under it
  assign norm  = s1_sum << (5'(PT + 1) - msb);
  assign exp_n = $signed({2'b00, s1_expo}) + $signed({6'b0, msb}) - 11'(PT);

  always_comb begin
    if (s1_sum == '0) begin
      res = '0;  // exact zero is +0
    end else if (exp_n <= 0) begin
      res = {s1_sign, {(`FMA_FLEN-1){1'b0}}};  // underflow, signed zero
    end else if (exp_n >= EXPO_MAX) begin
      res = {s1_sign, {`FMA_EXPO_W{1'b1}}, {`FMA_FRAC_W{1'b0}}};
    end else begin
      res = {s1_sign, exp_n[`FMA_EXPO_W-1:0], norm[PT -: `FMA_FRAC_W]};  // truncated
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      add_wb_valid <= 1'b0;
    end else begin
      add_wb_valid <= (s1_state == fma_pkg::add_busy);
    end
  end

  always_ff @(posedge clk) begin
    if (s1_state == fma_pkg::add_busy) begin
      add_wb_id     <= s1_id;
      add_wb_result <= res;
    end
  end

endmodule

`default_nettype wire

/* fma_unit_top.sv */
/*
 * fused multiply-add unit top: multiplier, fadd prep buffer and adder
 */
`timescale 1ns/1ps
`default_nettype none

module fma_unit_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             issue_valid,
  input  fma_pkg::fp_op_e  issue_op,
  input  fma_pkg::id_t     issue_id,
  input  fma_pkg::fp_t     rs1,
  input  fma_pkg::fp_t     rs2,
  input  fma_pkg::fp_t     rs3,
  output logic             issue_ready,
  output logic             mul_wb_valid,
  output fma_pkg::id_t     mul_wb_id,
  output fma_pkg::fp_t     mul_wb_result,
  output logic             add_wb_valid,
  output fma_pkg::id_t     add_wb_id,
  output fma_pkg::fp_t     add_wb_result
);

  logic            issue_fire;

  // product hand-off, mul -> add
  logic            prod_valid;
  fma_pkg::id_t    prod_id;
  logic            prod_sign;
  fma_pkg::expo_t  prod_expo;
  fma_pkg::prod_t  prod_mant;
  fma_pkg::fp_t    addend;
  logic            addend_neg;

  // queued addition, prep -> add
  logic            pend_valid;
  logic            pend_take;
  fma_pkg::id_t    pend_id;
  fma_pkg::fp_t    pend_big;
  fma_pkg::fp_t    pend_small;
  fma_pkg::expo_t  pend_diff;
  logic            pend_sub;

  assign issue_fire = issue_valid & issue_ready;

  ////////////////////////////////////////
  fp_mul u_fp_mul (
    .clk(clk), .rst_n(rst_n),
    .issue_fire(issue_fire), .issue_op(issue_op), .issue_id(issue_id),
    .rs1(rs1), .rs2(rs2), .rs3(rs3),
    .mul_wb_valid(mul_wb_valid), .mul_wb_id(mul_wb_id), .mul_wb_result(mul_wb_result),
    .prod_valid(prod_valid), .prod_id(prod_id), .prod_sign(prod_sign),
    .prod_expo(prod_expo), .prod_mant(prod_mant),
    .addend(addend), .addend_neg(addend_neg)
  );

  // only the prep buffer can refuse an issue
  fadd_prep u_fadd_prep (
    .clk(clk), .rst_n(rst_n),
    .issue_fire(issue_fire), .issue_op(issue_op), .issue_id(issue_id),
    .rs1(rs1), .rs2(rs2), .pend_take(pend_take),
    .prep_ready(issue_ready), .pend_valid(pend_valid), .pend_id(pend_id),
    .pend_big(pend_big), .pend_small(pend_small),
    .pend_diff(pend_diff), .pend_sub(pend_sub)
  );

  fp_add u_fp_add (
    .clk(clk), .rst_n(rst_n),
    .prod_valid(prod_valid), .prod_id(prod_id), .prod_sign(prod_sign),
    .prod_expo(prod_expo), .prod_mant(prod_mant),
    .addend(addend), .addend_neg(addend_neg),
    .pend_valid(pend_valid), .pend_id(pend_id), .pend_big(pend_big),
    .pend_small(pend_small), .pend_diff(pend_diff), .pend_sub(pend_sub),
    .pend_take(pend_take),
    .add_wb_valid(add_wb_valid), .add_wb_id(add_wb_id), .add_wb_result(add_wb_result)
  );

endmodule

`default_nettype wire

/* tb_fma_unit.sv */
/*
 * testbench for the fused multiply-add unit: random issue from an LCG,
 * bit-exact reference model, scoreboard by id, directed stall and corner cases
 */
`timescale 1ns/1ps
`default_nettype none

`include "fma_config.svh"

module tb_fma_unit;

  localparam int CLK_PERIOD = 100;
  localparam int N_ID       = 1 << `FMA_ID_W;
  localparam int N_RAND     = 400;
  localparam int N_DIR      = 16;  // corner ops plus the stall sequence
  localparam int WP         = 21;  // hidden bit position in the working mantissa

  logic             clk;
  logic             rst_n;
  logic             issue_valid;
  fma_pkg::fp_op_e  issue_op;
  fma_pkg::id_t     issue_id;
  fma_pkg::fp_t     rs1;
  fma_pkg::fp_t     rs2;
  fma_pkg::fp_t     rs3;
  logic             issue_ready;
  logic             mul_wb_valid;
  fma_pkg::id_t     mul_wb_id;
  fma_pkg::fp_t     mul_wb_result;
  logic             add_wb_valid;
  fma_pkg::id_t     add_wb_id;
  fma_pkg::fp_t     add_wb_result;

  // scoreboard, one slot per id
  logic             busy [N_ID];
  fma_pkg::fp_op_e  op_of [N_ID];
  fma_pkg::fp_t     exp_res [N_ID];
  int               issue_cyc [N_ID];
  int               ret_cyc [N_ID];
  fma_pkg::id_t     mul_q [$];  // fmul retires in issue order
  fma_pkg::id_t     next_id;
  int               cyc;        // posedges so far
  logic [31:0]      lcg_state;

  fma_unit_top u_fma_unit_top (
    .clk(clk), .rst_n(rst_n),
    .issue_valid(issue_valid), .issue_op(issue_op), .issue_id(issue_id),
    .rs1(rs1), .rs2(rs2), .rs3(rs3), .issue_ready(issue_ready),
    .mul_wb_valid(mul_wb_valid), .mul_wb_id(mul_wb_id), .mul_wb_result(mul_wb_result),
    .add_wb_valid(add_wb_valid), .add_wb_id(add_wb_id), .add_wb_result(add_wb_result)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////
  // failure reporting and compares
  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_fp(input string name, input fma_pkg::fp_t got,
                          input fma_pkg::fp_t expected);
    if (got !== expected) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
      stop_fail("wrong result value");
    end
  endtask

  task automatic check_id(input string name, input fma_pkg::id_t got,
                          input fma_pkg::id_t expected);
    if (got !== expected) begin
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, expected);
      stop_fail("wrong result id");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, expected);
      stop_fail("wrong control flag");
    end
  endtask

  ////////////////////////////////////////
  // stimulus source
  function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[30:16]) % n;  // upper bits, low ones are weak
  endfunction

  function automatic fma_pkg::fp_t rand_fp();
    int kind;
    int e;
    kind = rand_below(8);
    if (kind == 0) e = 0;                          // zero or subnormal
    else if (kind == 1) e = 200 + rand_below(55);  // overflows in pairs
    else if (kind == 2) e = 1 + rand_below(40);    // underflows in pairs
    else e = 112 + rand_below(32);
    return {rand_below(2) == 1, e[7:0], 7'(rand_below(128))};
  endfunction

  ////////////////////////////////////////
  // reference model
  function automatic int expo_of(input fma_pkg::fp_t x);
    return int'(x[`FMA_FLEN-2 -: `FMA_EXPO_W]);
  endfunction

  // mantissa with hidden bit at WP, zero expo is a zero value
  function automatic int work_of(input fma_pkg::fp_t x);
    if (expo_of(x) == 0) return 0;
    return (128 + int'(x[`FMA_FRAC_W-1:0])) << (WP - `FMA_FRAC_W);
  endfunction

  // normalize, truncate, flush or saturate
  function automatic fma_pkg::fp_t round_pack(input logic s, input int e, input int w);
    int top;
    int en;
    int frac;
    if (w == 0) return '0;  // exact zero sum is +0
    top = 0;
    for (int i = 0; i < `FMA_WORK_W; i++) begin
      if ((w >> i) & 1) top = i;
    end
    en = e + top - WP;
    if (en <= 0) return {s, 15'h0};
    if (en >= 255) return {s, 8'hff, 7'h0};
    frac = ((w << 7) >> top) & 'h7f;  // 7 bits under the leading one
    return {s, en[7:0], frac[6:0]};
  endfunction

  function automatic fma_pkg::fp_t add_pair(input logic sa, input int ea, input int wa,
                                            input logic sb, input int eb, input int wb);
    logic st;
    int   et;
    int   wt;
    int   sh;
    int   al;
    if (eb > ea || (eb == ea && wb > wa)) begin  // a ends up the larger magnitude
      st = sa;
      et = ea;
      wt = wa;
      sa = sb;
      ea = eb;
      wa = wb;
      sb = st;
      eb = et;
      wb = wt;
    end
    sh = ea - eb;
    al = (sh >= `FMA_WORK_W) ? 0 : (wb >> sh);  // shifted-out bits are lost
    return round_pack(sa, ea, (sa == sb) ? wa + al : wa - al);
  endfunction

  function automatic fma_pkg::fp_t ref_result(input fma_pkg::fp_op_e op, input fma_pkg::fp_t a,
                                              input fma_pkg::fp_t b, input fma_pkg::fp_t c);
    logic ps;
    logic bs;
    logic cs;
    int   pe;
    int   pw;
    int   m;
    bs = b[`FMA_FLEN-1] ^ (op == fma_pkg::op_fsub);
    cs = c[`FMA_FLEN-1] ^ (op == fma_pkg::op_fmsub);
    if (op == fma_pkg::op_fadd || op == fma_pkg::op_fsub)
      return add_pair(a[`FMA_FLEN-1], expo_of(a), work_of(a), bs, expo_of(b), work_of(b));
    // exact product, flushed when its exponent falls below 0
    ps = a[`FMA_FLEN-1] ^ b[`FMA_FLEN-1];
    m  = (128 + int'(a[`FMA_FRAC_W-1:0])) * (128 + int'(b[`FMA_FRAC_W-1:0]));
    pe = expo_of(a) + expo_of(b) - `FMA_BIAS;
    pw = 0;
    if (expo_of(a) != 0 && expo_of(b) != 0 && pe >= 0) begin
      if (m >= (1 << 15)) begin
        pe = pe + 1;
        pw = m << (WP - 15);
      end else begin
        pw = m << (WP - 14);
      end
    end
    if (op == fma_pkg::op_fmul)
      return (pw == 0) ? {ps, 15'h0} : round_pack(ps, pe, pw);  // fmul keeps zero sign
    return add_pair(ps, (pw == 0) ? 0 : pe, pw, cs, expo_of(c), work_of(c));
  endfunction

  ////////////////////////////////////////
  // issue and retire
  task automatic send(input fma_pkg::fp_op_e op, input fma_pkg::fp_t a, input fma_pkg::fp_t b,
                      input fma_pkg::fp_t c, output fma_pkg::id_t id);
    id = next_id;
    while (busy[id]) @(negedge clk);  // id reuse only after retire
    issue_valid = 1'b1;
    issue_op    = op;
    issue_id    = id;
    rs1         = a;
    rs2         = b;
    rs3         = c;
    while (!issue_ready) @(negedge clk);  // hold the request
    busy[id]      = 1'b1;
    op_of[id]     = op;
    issue_cyc[id] = cyc + 1;  // fires on the coming posedge
    exp_res[id]   = ref_result(op, a, b, c);
    if (op == fma_pkg::op_fmul) mul_q.push_back(id);
    next_id = id + 1'b1;
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  function automatic logic all_retired();
    for (int i = 0; i < N_ID; i++) begin
      if (busy[i]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic drain();
    while (!all_retired()) @(negedge clk);
  endtask

  always @(negedge clk) begin : monitor
    fma_pkg::id_t id;
    int           lat;  // issue posedge to the posedge that samples the valid
    if (rst_n && mul_wb_valid) begin
      if (mul_q.size() == 0) begin
        stop_fail("fmul write-back with no fmul in flight");
      end else begin
        id = mul_q.pop_front();
        check_id("mul_wb_id", mul_wb_id, id);
        check_fp("mul_wb_result", mul_wb_result, exp_res[id]);
        lat = cyc + 1 - issue_cyc[id];
        if (lat != 2)
          stop_fail($sformatf("fmul id %0d took %0d cycles", id, lat));
        busy[id]    = 1'b0;
        ret_cyc[id] = cyc;
      end
    end
    if (rst_n && add_wb_valid) begin
      id = add_wb_id;
      if (!busy[id] || op_of[id] == fma_pkg::op_fmul) begin
        stop_fail($sformatf("add write-back with unknown or duplicate id %0d", id));
      end else begin
        check_fp("add_wb_result", add_wb_result, exp_res[id]);
        lat = cyc + 1 - issue_cyc[id];
        if ((op_of[id] == fma_pkg::op_fmadd || op_of[id] == fma_pkg::op_fmsub) &&
            lat != 4)
          stop_fail($sformatf("fused id %0d took %0d cycles", id, lat));
        busy[id]    = 1'b0;
        ret_cyc[id] = cyc;
      end
    end
  end

  // ends the run if the DUT stops answering
  initial begin : watchdog
    #(CLK_PERIOD * (10 * (N_RAND + N_DIR) + 50));
    stop_fail("watchdog timeout, results stopped arriving");
  end

  ////////////////////////////////////////
  initial begin : main
    fma_pkg::id_t     id;
    fma_pkg::id_t     fused_ids [4];
    fma_pkg::id_t     add_id;
    fma_pkg::fp_op_e  op;
    fma_pkg::fp_t     a;
    fma_pkg::fp_t     b;
    fma_pkg::fp_t     c;
    clk         = 1'b0;
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue_op    = fma_pkg::op_fmul;
    issue_id    = '0;
    rs1         = '0;
    rs2         = '0;
    rs3         = '0;
    cyc         = 0;
    next_id     = '0;
    lcg_state   = 32'h4eed;
    for (int i = 0; i < N_ID; i++) busy[i] = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_flag("issue_ready", issue_ready, 1'b1);
    check_flag("mul_wb_valid", mul_wb_valid, 1'b0);
    check_flag("add_wb_valid", add_wb_valid, 1'b0);

    // corner cases
    send(fma_pkg::op_fmul, 16'h3fc0, 16'h4000, '0, id);       // 1.5 * 2
    send(fma_pkg::op_fmul, 16'h0000, 16'hc000, '0, id);       // signed zero
    send(fma_pkg::op_fmul, 16'h7e00, 16'h7e00, '0, id);       // overflow to inf
    send(fma_pkg::op_fmul, 16'h8080, 16'h0080, '0, id);       // underflow, -0
    send(fma_pkg::op_fsub, 16'h4049, 16'h4049, '0, id);       // cancels to +0
    send(fma_pkg::op_fadd, 16'h3f81, 16'hbfc0, '0, id);       // equal expo, swap
    send(fma_pkg::op_fmadd, 16'h3fc0, 16'h4000, 16'h3f80, id);
    send(fma_pkg::op_fmsub, 16'h3f80, 16'h3f80, 16'h3f80, id);  // exact zero
    send(fma_pkg::op_fadd, 16'h4b00, 16'h3f80, '0, id);       // small one drops out
    send(fma_pkg::op_fmadd, 16'h7f00, 16'h4000, 16'h0000, id);
    drain();

    // fused run ahead of a queued fadd
    for (int i = 0; i < 4; i++) begin
      send(fma_pkg::op_fmadd, 16'h3fc0 + 16'(i), 16'h4000, 16'h3f80, id);
      fused_ids[i] = id;
    end
    send(fma_pkg::op_fadd, 16'h4040, 16'h3f80, '0, add_id);
    check_flag("issue_ready", issue_ready, 1'b0);  // buffer stuck behind products
    send(fma_pkg::op_fmsub, 16'h4000, 16'h4000, 16'h3f80, id);
    drain();
    for (int i = 0; i < 4; i++) begin
      if (ret_cyc[add_id] <= ret_cyc[fused_ids[i]])
        stop_fail("queued fadd retired ahead of an older fused op");
    end

    ////////////////////////////////////////
    // random mix
    for (int n = 0; n < N_RAND; n++) begin
      op = fma_pkg::fp_op_e'(rand_below(5));
      a  = rand_fp();
      b  = rand_fp();
      c  = rand_fp();
      if (op == fma_pkg::op_fadd || op == fma_pkg::op_fsub) begin
        case (rand_below(6))
          0: b = a;                                 // fsub cancels
          1: b = a ^ 16'h8000;                      // fadd cancels
          2: b = {b[15], a[14:7], b[6:0]};          // same exponent
          default: ;
        endcase
      end
      if (rand_below(4) == 0) @(negedge clk);  // idle gap
      send(op, a, b, c, id);
    end
    drain();
    repeat (8) @(negedge clk);  // quiet time for stray write-backs

    if (all_retired() && mul_q.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_fail("some issued ids never retired");
    end
  end

endmodule

`default_nettype wire

/* fma_unit_top.f */
+incdir+.
fma_pkg.sv
fp_mul.sv
fadd_prep.sv
fp_add.sv
fma_unit_top.sv
tb_fma_unit.sv

/* Makefile */
# Verilator lint, simulation and clean for the fused multiply-add unit

TB  = tb_fma_unit
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f fma_unit_top.f --top-module fma_unit_top

sim:
	verilator --binary --timing -Wno-fatal -f fma_unit_top.f --top-module $(TB)
	-./obj_dir/V$(TB) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
